// ==== files.f ====
hw/cdc_pkg.sv
hw/gray_ptr_sync.sv
hw/fifo_ku.sv
hw/fifo_a1.sv
hw/xilinx_fifo_verb.sv
hw/cdc_bridge_top.sv
testbench/tb_cdc_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cdc bridge testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cdc_bridge \
    -f files.f -o tb_cdc_bridge > build.log 2>&1 ||
    { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_cdc_bridge > sim.log 2>&1
sim_status=$?
cat sim.log

grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
[ "$sim_status" -eq 0 ] || { echo "simulation exited abnormally"; exit 1; }
echo "simulation passed"

// ==== testbench/tb_cdc_bridge.sv ====
/* testbench for the two way cdc bridge
   directed tests on the fwft forward channel and the standard read return channel */
`timescale 1ns/10ps

module tb_cdc_bridge import cdc_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LFSR_SEED      = 32'he59e_4efb;

    logic               wr_clk;
    logic               rd_clk;
    logic               rst_n;
    sample_t            fwd_din;
    logic               fwd_wr_en;
    logic               fwd_full;
    logic [FIFO_CW-1:0] fwd_wrcount;
    logic               fwd_rd_en;
    sample_t            fwd_dout;
    logic               fwd_empty;
    logic [FIFO_CW-1:0] fwd_rdcount;
    ctrl_t              ret_din;
    logic               ret_wr_en;
    logic               ret_full;
    logic [FIFO_CW-1:0] ret_wrcount;
    logic               ret_rd_en;
    ctrl_t              ret_dout;
    logic               ret_empty;
    logic [FIFO_CW-1:0] ret_rdcount;

    // reference queues per channel
    sample_t     fwd_q[$];
    ctrl_t       ret_q[$];
    // standard read check lands one wr_clk later
    ctrl_t       ret_exp;
    logic        ret_pend;
    int          fwd_wr_cnt;
    logic [31:0] lfsr;
    int          err_data;
    int          err_count;
    int          err_flag;
    int          err_other;
    int          cycles;

    cdc_bridge_top cdc_bridge_top_i (.*);

    ////////////////////////////////////////////////////////////
    // clocks with rd_clk 3 ns behind wr_clk
    ////////////////////////////////////////////////////////////

    initial begin
        wr_clk = 1'b0;
        forever #4 wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        #3;
        forever #4 rd_clk = ~rd_clk;
    end

    ////////////////////////////////////////////////////////////
    // random source and compare tasks
    ////////////////////////////////////////////////////////////

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic coin(output logic b);
        logic [31:0] v;
        take_bits(1, v);
        b = v[0];
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            err_data++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string what);
        if (got !== exp) begin
            err_data++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [FIFO_CW-1:0] got, input logic [FIFO_CW-1:0] exp,
                               input string what);
        if (got !== exp) begin
            err_count++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_flag++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // per edge steps called right after the clock edge
    ////////////////////////////////////////////////////////////

    // wr_clk side where a strobe counts only when full was low at the edge
    task automatic fwd_write_step(input logic en);
        logic [31:0] v;
        if (fwd_wr_en && !fwd_full) begin
            fwd_q.push_back(fwd_din);
            fwd_wr_cnt++;
        end
        if (en) begin
            take_bits($bits(sample_t), v);
            fwd_din <= v[$bits(sample_t)-1:0];
        end
        fwd_wr_en <= en;
    endtask

    // rd_clk side with the fwft head on dout before the accepting edge
    task automatic fwd_read_step(input logic en);
        if (fwd_rd_en && !fwd_empty) begin
            if (fwd_q.size() == 0) begin
                err_other++;
                $display("forward channel gave a record that was never written, at %0d ns",
                         $time);
            end else begin
                check_sample(fwd_dout, fwd_q.pop_front(), "fwd_dout");
            end
        end
        fwd_rd_en <= en;
    endtask

    // return channel writer in rd_clk
    task automatic ret_write_step(input logic en);
        logic [31:0] v;
        if (ret_wr_en && !ret_full) begin
            ret_q.push_back(ret_din);
        end
        if (en) begin
            take_bits($bits(ctrl_t), v);
            ret_din <= v[$bits(ctrl_t)-1:0];
        end
        ret_wr_en <= en;
    endtask

    // data of the previous accepted read shows up at this wr_clk edge
    task automatic ret_read_step(input logic en);
        if (ret_pend) begin
            check_ctrl(ret_dout, ret_exp, "ret_dout");
            ret_pend = 1'b0;
        end
        if (ret_rd_en && !ret_empty) begin
            if (ret_q.size() == 0) begin
                err_other++;
                $display("return channel gave a record that was never written, at %0d ns",
                         $time);
            end else begin
                ret_exp  = ret_q.pop_front();
                ret_pend = 1'b1;
            end
        end
        ret_rd_en <= en;
    endtask

    task automatic write_fwd(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge wr_clk);
            fwd_write_step(1'b1);
        end
        @(posedge wr_clk);
        fwd_write_step(1'b0);
    endtask

    task automatic write_ret(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge rd_clk);
            ret_write_step(1'b1);
        end
        @(posedge rd_clk);
        ret_write_step(1'b0);
    endtask

    task automatic drain_fwd();
        while (fwd_q.size() != 0) begin
            @(posedge rd_clk);
            fwd_read_step(1'b1);
            if (fwd_q.size() == 0) begin
                fwd_rd_en <= 1'b0;
            end
        end
    endtask

    task automatic drain_ret();
        while (ret_q.size() != 0 || ret_pend) begin
            @(posedge wr_clk);
            ret_read_step(1'b1);
            if (ret_q.size() == 0) begin
                ret_rd_en <= 1'b0;
            end
        end
    endtask

    // both channels settled and empty
    task automatic check_idle();
        repeat (5) @(posedge wr_clk);
        check_flag(fwd_empty, 1'b1, "fwd_empty");
        check_flag(fwd_full, 1'b0, "fwd_full");
        check_count(fwd_wrcount, '0, "fwd_wrcount");
        check_count(fwd_rdcount, '0, "fwd_rdcount");
        check_flag(ret_empty, 1'b1, "ret_empty");
        check_flag(ret_full, 1'b0, "ret_full");
        check_count(ret_wrcount, '0, "ret_wrcount");
        check_count(ret_rdcount, '0, "ret_rdcount");
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic after_reset();
        check_idle();
        check_ctrl(ret_dout, '0, "ret_dout after reset");
    endtask

    task automatic fwft_order();
        write_fwd(10);
        // first word falls through 2 to 3 rd_clk cycles later
        while (fwd_empty) begin
            @(posedge rd_clk);
        end
        drain_fwd();
        check_idle();
    endtask

    task automatic standard_read();
        write_ret(10);
        drain_ret();
        check_idle();
    endtask

    task automatic fill_and_overflow();
        int start;
        int n_acc;
        start = fwd_wr_cnt;
        for (int i = 0; i <= FIFO_DEPTH + 3; i++) begin
            @(posedge wr_clk);
            // idle reader keeps wrcount exact
            n_acc = fwd_wr_cnt - start;
            check_flag(fwd_full, n_acc >= FIFO_DEPTH, "fwd_full while filling");
            check_count(fwd_wrcount, FIFO_CW'(n_acc), "fwd_wrcount while filling");
            fwd_write_step(i < FIFO_DEPTH + 3);
        end
        n_acc = fwd_wr_cnt - start;
        check_count(FIFO_CW'(n_acc), FIFO_CW'(FIFO_DEPTH), "accepted forward writes");
        check_count(fwd_wrcount, FIFO_CW'(FIFO_DEPTH), "fwd_wrcount when full");
        drain_fwd();
        // the three dropped records must not come out
        check_idle();
    endtask

    task automatic underflow_and_counts();
        sample_t fwd_hold;
        ctrl_t   ret_hold;
        fwd_hold = fwd_dout;
        ret_hold = ret_dout;
        // strobes while empty are ignored
        fork
            begin
                repeat (6) begin
                    @(posedge rd_clk);
                    check_flag(fwd_empty, 1'b1, "fwd_empty on underflow");
                    check_count(fwd_rdcount, '0, "fwd_rdcount on underflow");
                    check_count(ret_wrcount, '0, "ret_wrcount on underflow");
                    fwd_read_step(1'b1);
                end
                @(posedge rd_clk);
                fwd_read_step(1'b0);
            end
            begin
                repeat (6) begin
                    @(posedge wr_clk);
                    check_flag(ret_empty, 1'b1, "ret_empty on underflow");
                    check_count(ret_rdcount, '0, "ret_rdcount on underflow");
                    check_count(fwd_wrcount, '0, "fwd_wrcount on underflow");
                    ret_read_step(1'b1);
                end
                @(posedge wr_clk);
                ret_read_step(1'b0);
            end
        join
        check_sample(fwd_dout, fwd_hold, "fwd_dout after underflow");
        check_ctrl(ret_dout, ret_hold, "ret_dout after underflow");
        fork
            write_fwd(5);
            write_ret(5);
        join
        repeat (4) @(posedge wr_clk);
        check_count(fwd_wrcount, FIFO_CW'(5), "fwd_wrcount at rest");
        check_count(fwd_rdcount, FIFO_CW'(5), "fwd_rdcount at rest");
        check_count(ret_wrcount, FIFO_CW'(5), "ret_wrcount at rest");
        check_count(ret_rdcount, FIFO_CW'(5), "ret_rdcount at rest");
        fork
            drain_fwd();
            drain_ret();
        join
        check_idle();
    endtask

    task automatic concurrent_traffic();
        logic wr_a;
        logic wr_b;
        logic rd_a;
        logic rd_b;
        // one process per clock domain keeps the lfsr order fixed
        fork
            begin
                repeat (300) begin
                    @(posedge wr_clk);
                    coin(wr_a);
                    coin(wr_b);
                    fwd_write_step(wr_a);
                    ret_read_step(wr_b);
                end
                @(posedge wr_clk);
                fwd_write_step(1'b0);
                ret_read_step(1'b0);
            end
            begin
                repeat (300) begin
                    @(posedge rd_clk);
                    coin(rd_a);
                    coin(rd_b);
                    fwd_read_step(rd_a);
                    ret_write_step(rd_b);
                end
                @(posedge rd_clk);
                fwd_read_step(1'b0);
                ret_write_step(1'b0);
            end
        join
        fork
            drain_fwd();
            drain_ret();
        join
        check_idle();
    endtask

    task automatic end_run(input logic timed_out);
        int total;
        total = err_data + err_count + err_flag + err_other;
        $display("errors: data %0d, count %0d, flag %0d, other %0d",
                 err_data, err_count, err_flag, err_other);
        if (timed_out || total != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge wr_clk);
            cycles++;
        end
        $display("run timed out after %0d wr_clk cycles", cycles);
        end_run(1'b1);
    end

    initial begin
        lfsr       = LFSR_SEED;
        ret_pend   = 1'b0;
        fwd_wr_cnt = 0;
        err_data   = 0;
        err_count  = 0;
        err_flag   = 0;
        err_other  = 0;
        fwd_din    = '0;
        fwd_wr_en  = 1'b0;
        fwd_rd_en  = 1'b0;
        ret_din    = '0;
        ret_wr_en  = 1'b0;
        ret_rd_en  = 1'b0;
        rst_n      = 1'b0;
        repeat (3) @(posedge wr_clk);
        // release between edges of both clocks
        #2;
        rst_n = 1'b1;
        after_reset();
        fwft_order();
        standard_read();
        fill_and_overflow();
        underflow_and_counts();
        concurrent_traffic();
        end_run(1'b0);
    end

endmodule

// ==== hw/cdc_bridge_top.sv ====
/* two way clock domain bridge
   forward samples wr_clk to rd_clk, control records back to wr_clk */
`timescale 1ns/10ps

module cdc_bridge_top import cdc_pkg::*; (
    input  logic               wr_clk,
    input  logic               rd_clk,
    input  logic               rst_n,
    // forward channel, write side in wr_clk
    input  sample_t            fwd_din,
    input  logic               fwd_wr_en,
    output logic               fwd_full,
    output logic [FIFO_CW-1:0] fwd_wrcount,
    // forward channel, read side in rd_clk
    input  logic               fwd_rd_en,
    output sample_t            fwd_dout,
    output logic               fwd_empty,
    output logic [FIFO_CW-1:0] fwd_rdcount,
    // return channel, write side in rd_clk
    input  ctrl_t              ret_din,
    input  logic               ret_wr_en,
    output logic               ret_full,
    output logic [FIFO_CW-1:0] ret_wrcount,
    // return channel, read side in wr_clk
    input  logic               ret_rd_en,
    output ctrl_t              ret_dout,
    output logic               ret_empty,
    output logic [FIFO_CW-1:0] ret_rdcount
);

    ////////////////////////////////////////////////////////////
    // forward channel
    ////////////////////////////////////////////////////////////

    xilinx_fifo_verb #(
        .payload_t (sample_t),
        .FAMILY    (FWD_FAMILY)
    ) fwd_fifo (
        .wr_clk  (wr_clk),
        .rd_clk  (rd_clk),
        .rst_n   (rst_n),
        .din     (fwd_din),
        .wr_en   (fwd_wr_en),
        .rd_en   (fwd_rd_en),
        .dout    (fwd_dout),
        .full    (fwd_full),
        .empty   (fwd_empty),
        .wrcount (fwd_wrcount),
        .rdcount (fwd_rdcount)
    );

    ////////////////////////////////////////////////////////////
    // return channel
    ////////////////////////////////////////////////////////////

    // clocks swapped, written in rd_clk
    xilinx_fifo_verb #(
        .payload_t (ctrl_t),
        .FAMILY    (RET_FAMILY)
    ) ret_fifo (
        .wr_clk  (rd_clk),
        .rd_clk  (wr_clk),
        .rst_n   (rst_n),
        .din     (ret_din),
        .wr_en   (ret_wr_en),
        .rd_en   (ret_rd_en),
        .dout    (ret_dout),
        .full    (ret_full),
        .empty   (ret_empty),
        .wrcount (ret_wrcount),
        .rdcount (ret_rdcount)
    );

endmodule

// ==== hw/xilinx_fifo_verb.sv ====
/* family selecting dual clock fifo wrapper
   fwft core for ultrascale parts, standard read core otherwise */
`timescale 1ns/10ps

module xilinx_fifo_verb import cdc_pkg::*; #(
    parameter type   payload_t = sample_t,
    parameter string FAMILY    = FWD_FAMILY
) (
    input  logic               wr_clk,
    input  logic               rd_clk,
    input  logic               rst_n,
    input  payload_t           din,
    input  logic               wr_en,
    input  logic               rd_en,
    output payload_t           dout,
    output logic               full,
    output logic               empty,
    output logic [FIFO_CW-1:0] wrcount,
    output logic [FIFO_CW-1:0] rdcount
);

    ////////////////////////////////////////////////////////////
    // core select, only one branch elaborates
    ////////////////////////////////////////////////////////////

    generate
        if (FAMILY == "kintexu" || FAMILY == "ultrascale") begin : g_ku
            // first word fall through
            fifo_ku #(
                .payload_t (payload_t)
            ) fifo_ku_i (
                .wr_clk  (wr_clk),
                .rd_clk  (rd_clk),
                .rst_n   (rst_n),
                .din     (din),
                .wr_en   (wr_en),
                .rd_en   (rd_en),
                .dout    (dout),
                .full    (full),
                .empty   (empty),
                .wrcount (wrcount),
                .rdcount (rdcount)
            );
        end else begin : g_a1
            // standard read, data one cycle after rd_en
            fifo_a1 #(
                .payload_t (payload_t)
            ) fifo_a1_i (
                .wr_clk  (wr_clk),
                .rd_clk  (rd_clk),
                .rst_n   (rst_n),
                .din     (din),
                .wr_en   (wr_en),
                .rd_en   (rd_en),
                .dout    (dout),
                .full    (full),
                .empty   (empty),
                .wrcount (wrcount),
                .rdcount (rdcount)
            );
        end
    endgenerate

endmodule

// ==== hw/fifo_a1.sv ====
/* dual clock fifo, standard read
   dout is registered at the accepting read edge, counts on both sides */
`timescale 1ns/10ps

module fifo_a1 import cdc_pkg::*; #(
    parameter type payload_t = ctrl_t
) (
    input  logic               wr_clk,
    input  logic               rd_clk,
    input  logic               rst_n,
    input  payload_t           din,
    input  logic               wr_en,
    input  logic               rd_en,
    output payload_t           dout,
    output logic               full,
    output logic               empty,
    output logic [FIFO_CW-1:0] wrcount,
    output logic [FIFO_CW-1:0] rdcount
);

    // storage, written in wr_clk only
    payload_t mem [FIFO_DEPTH];

    // write domain
    logic               wr_ok;
    logic [FIFO_CW-1:0] wptr;
    logic [FIFO_CW-1:0] wptr_next;
    logic [FIFO_CW-1:0] rptr_wr;
    logic [FIFO_CW-1:0] wr_fill;
    // read domain
    logic               rd_ok;
    logic [FIFO_CW-1:0] rptr;
    logic [FIFO_CW-1:0] rptr_next;
    logic [FIFO_CW-1:0] wptr_rd;
    logic [FIFO_CW-1:0] rd_fill;

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    // drop writes while full
    assign wr_ok     = wr_en & ~full;
    assign wptr_next = wptr + FIFO_CW'(wr_ok);
    assign wr_fill   = wptr_next - rptr_wr;

    always_ff @(posedge wr_clk) begin
        if (wr_ok) begin
            mem[wptr[FIFO_AW-1:0]] <= din;
        end
    end

    // full and wrcount move on the accepting edge
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr    <= '0;
            wrcount <= '0;
            full    <= 1'b0;
        end else begin
            wptr    <= wptr_next;
            wrcount <= wr_fill;
            full    <= (wr_fill == FIFO_CW'(FIFO_DEPTH));
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // drop reads while empty
    assign rd_ok     = rd_en & ~empty;
    assign rptr_next = rptr + FIFO_CW'(rd_ok);
    // synced write pointer lags, never overstates
    assign rd_fill   = wptr_rd - rptr_next;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr    <= '0;
            rdcount <= '0;
            empty   <= 1'b1;
        end else begin
            rptr    <= rptr_next;
            rdcount <= rd_fill;
            empty   <= (rd_fill == '0);
        end
    end

    // head lands on dout one cycle after the strobe
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (rd_ok) begin
            dout <= mem[rptr[FIFO_AW-1:0]];
        end
    end

    ////////////////////////////////////////////////////////////
    // pointer crossings
    ////////////////////////////////////////////////////////////

    gray_ptr_sync wptr_sync_i (
        .dst_clk (rd_clk),
        .rst_n   (rst_n),
        .src_clk (wr_clk),
        .src_bin (wptr_next),
        .dst_bin (wptr_rd)
    );

    gray_ptr_sync rptr_sync_i (
        .dst_clk (wr_clk),
        .rst_n   (rst_n),
        .src_clk (rd_clk),
        .src_bin (rptr_next),
        .dst_bin (rptr_wr)
    );

    a_wrcount_max : assert property (@(posedge wr_clk) disable iff (!rst_n)
        wrcount <= FIFO_CW'(FIFO_DEPTH));

    a_empty_count : assert property (@(posedge rd_clk) disable iff (!rst_n)
        !empty |-> rdcount != '0);

endmodule

// ==== hw/fifo_ku.sv ====
/* dual clock fifo with first word fall through read
   a one entry output stage presents the head and both sides report occupancy */
`timescale 1ns/10ps

module fifo_ku import cdc_pkg::*; #(
    parameter type payload_t = sample_t
) (
    input  logic               wr_clk,
    input  logic               rd_clk,
    input  logic               rst_n,
    input  payload_t           din,
    input  logic               wr_en,
    input  logic               rd_en,
    output payload_t           dout,
    output logic               full,
    output logic               empty,
    output logic [FIFO_CW-1:0] wrcount,
    output logic [FIFO_CW-1:0] rdcount
);

    // storage written in wr_clk only
    payload_t mem [FIFO_DEPTH];

    // write domain
    logic               wr_ok;
    logic [FIFO_CW-1:0] wptr;
    logic [FIFO_CW-1:0] wptr_next;
    logic [FIFO_CW-1:0] rptr_wr;
    logic [FIFO_CW-1:0] wr_fill;
    // read domain
    logic               rd_ok;
    logic               stage_load;
    logic [FIFO_CW-1:0] rptr;
    logic [FIFO_CW-1:0] rptr_next;
    logic [FIFO_CW-1:0] wptr_rd;
    logic [FIFO_CW-1:0] rd_avail;

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    // writes while full are dropped
    assign wr_ok     = wr_en & ~full;
    assign wptr_next = wptr + FIFO_CW'(wr_ok);
    // lagging remote pointer never lets this understate
    assign wr_fill   = wptr_next - rptr_wr;

    always_ff @(posedge wr_clk) begin
        if (wr_ok) begin
            mem[wptr[FIFO_AW-1:0]] <= din;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr    <= '0;
            wrcount <= '0;
            full    <= 1'b0;
        end else begin
            wptr    <= wptr_next;
            wrcount <= wr_fill;
            full    <= (wr_fill == FIFO_CW'(FIFO_DEPTH));
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // empty mirrors the output stage so reads pop the stage
    assign rd_ok     = rd_en & ~empty;
    // rptr counts user reads and the stage holds mem[rptr]
    assign rptr_next = rptr + FIFO_CW'(rd_ok);
    // entries from the new head on including the stage entry
    assign rd_avail  = wptr_rd - rptr_next;
    // refill the stage when it empties or gets popped
    assign stage_load = (empty | rd_ok) & (rd_avail != '0);

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr    <= '0;
            rdcount <= '0;
            empty   <= 1'b1;
        end else begin
            rptr    <= rptr_next;
            rdcount <= rd_avail;
            empty   <= (rd_avail == '0);
        end
    end

    // output stage loads the next head
    always_ff @(posedge rd_clk) begin
        if (stage_load) begin
            dout <= mem[rptr_next[FIFO_AW-1:0]];
        end
    end

    ////////////////////////////////////////////////////////////
    // pointer crossings
    ////////////////////////////////////////////////////////////

    // write pointer into rd_clk
    gray_ptr_sync wptr_sync_i (
        .dst_clk (rd_clk),
        .rst_n   (rst_n),
        .src_clk (wr_clk),
        .src_bin (wptr_next),
        .dst_bin (wptr_rd)
    );

    // user read pointer into wr_clk
    // the stage slot stays reserved until popped
    gray_ptr_sync rptr_sync_i (
        .dst_clk (wr_clk),
        .rst_n   (rst_n),
        .src_clk (rd_clk),
        .src_bin (rptr_next),
        .dst_bin (rptr_wr)
    );

    a_wrcount_max : assert property (@(posedge wr_clk) disable iff (!rst_n)
        wrcount <= FIFO_CW'(FIFO_DEPTH));

    a_empty_count : assert property (@(posedge rd_clk) disable iff (!rst_n)
        !empty |-> rdcount != '0);

endmodule

// ==== hw/gray_ptr_sync.sv ====
/* gray pointer crossing
   binary to gray, two flop synchronizer, gray back to binary */
`timescale 1ns/10ps

module gray_ptr_sync import cdc_pkg::*; (
    input  logic               dst_clk,
    input  logic               rst_n,
    input  logic               src_clk,
    input  logic [FIFO_CW-1:0] src_bin,
    output logic [FIFO_CW-1:0] dst_bin
);

    // source side gray register
    logic [FIFO_CW-1:0] src_gray;
    // destination side synchronizer stages
    logic [FIFO_CW-1:0] sync_1;
    logic [FIFO_CW-1:0] sync_2;

    // src_bin is the next pointer, so the gray flop tracks the pointer flop
    always_ff @(posedge src_clk or negedge rst_n) begin
        if (!rst_n) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_bin ^ (src_bin >> 1);
        end
    end

    // two flops in the destination domain
    always_ff @(posedge dst_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= src_gray;
            sync_2 <= sync_1;
        end
    end

    // gray decode, each bit is the xor of all higher gray bits
    always_comb begin
        for (int i = 0; i < FIFO_CW; i++) begin
            dst_bin[i] = ^(sync_2 >> i);
        end
    end

    // a multi bit step could be sampled half old, half new
    a_gray_one_bit : assert property (@(posedge src_clk) disable iff (!rst_n)
        $countones(src_gray ^ $past(src_gray)) <= 1);

endmodule

// ==== hw/cdc_pkg.sv ====
/* cdc bridge shared definitions
   fifo geometry, family names and the record types of both channels */
package cdc_pkg;

    ////////////////////////////////////////////////////////////
    // fifo geometry
    ////////////////////////////////////////////////////////////

    // entries per fifo, power of two
    localparam int FIFO_DEPTH = 16;

    // address bits into the memory
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // pointer and count width
    // one extra bit tells full from empty
    localparam int FIFO_CW = FIFO_AW + 1;

    ////////////////////////////////////////////////////////////
    // device families
    ////////////////////////////////////////////////////////////

    // forward channel, fwft core
    localparam string FWD_FAMILY = "kintexu";

    // return channel, standard read core
    localparam string RET_FAMILY = "artix7";

    ////////////////////////////////////////////////////////////
    // channel records
    ////////////////////////////////////////////////////////////

    // forward sample, wr_clk to rd_clk
    typedef struct packed {
        // source channel
        logic [3:0]  chan;
        // per channel sequence number
        logic [7:0]  seq;
        // sample value
        logic [15:0] data;
    } sample_t;

    // return control word, rd_clk to wr_clk
    typedef struct packed {
        // command code
        logic [2:0] cmd;
        // command argument
        logic [8:0] arg;
    } ctrl_t;

endpackage
